// File: Makefile
# Verilator build and run for the task unit testbench

VERILATOR ?= verilator
TOP       ?= tb_task_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= test passed

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_mem_model.sv
// testbench memory model
`timescale 1ns/1ps

module tb_mem_model import mflow_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  rd_req_t    rd_req,
   input  logic       rd_valid,
   output logic       rd_ready,
   output word_t      rd_data,
   output logic       rd_resp_valid,

   input  wr_req_t    wr_req,
   input  logic       wr_valid,
   output logic       wr_ready,

   input  logic       rd_gate,     // random accept enables
   input  logic       wr_gate,
   input  logic [1:0] rd_delay,    // extra response cycles

   input  logic       poke_en,     // backdoor preset port
   input  addr_t      poke_addr,
   input  word_t      poke_data
);

   localparam int WORDS = 4096;   // 16 KB

   word_t      mem [WORDS];
   logic       busy;
   logic [1:0] wait_cnt;
   addr_t      rd_addr;

   wr_req_t    wr_log [$];    // accepted writes in order
   time        wr_time [$];

   assign rd_ready = rd_gate && !busy;
   assign wr_ready = wr_gate;

   always @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= (word_t'(i) << 2) * 32'h9e3779b1 + 32'h5a5a0000;
         end
         busy          <= 1'b0;
         wait_cnt      <= '0;
         rd_addr       <= '0;
         rd_data       <= '0;
         rd_resp_valid <= 1'b0;
      end else begin
         rd_resp_valid <= 1'b0;
         if (rd_valid && rd_ready) begin
            busy     <= 1'b1;
            wait_cnt <= rd_delay;
            rd_addr  <= rd_req.addr;
         end else if (busy) begin
            if (wait_cnt == 2'd0) begin
               rd_resp_valid <= 1'b1;
               rd_data       <= mem[rd_addr[13:2]];
               busy          <= 1'b0;
            end else begin
               wait_cnt <= wait_cnt - 2'd1;
            end
         end
         if (wr_valid && wr_ready) begin
            mem[wr_req.addr[13:2]] <= wr_req.data;
            wr_log.push_back(wr_req);
            wr_time.push_back($time);
         end
         if (poke_en) begin
            mem[poke_addr[13:2]] <= poke_data;
         end
      end
   end

endmodule

// File: verif/tb_task_unit.sv
// task unit testbench
`timescale 1ns/1ps

module tb_task_unit import mflow_pkg::*;;

   localparam int    PER_TEST_CYCLES = 200;   // generous bound per test
   localparam addr_t VTX_BASE        = 32'h400;
   localparam vid_t  SRC_NODE        = 32'd1;
   localparam vid_t  SNK_NODE        = 32'd2;
   localparam word_t FLOW_SLOTS      = 32'd16;   // 2**FLOW_IDX_W

   typedef struct {
      string  name;
      ttype_t ttype;
      vid_t   obj;
      word_t  arg0;
      word_t  arg1;
      ts_t    ts;
      word_t  excess;       // preset vertex data
      word_t  height;
      word_t  flow;
      word_t  new_excess;   // expected stores
      word_t  new_flow;
      logic   child;
      task_t  child_task;
   } test_t;

   logic        clk = 1'b0;
   logic        rstn;
   logic        start;
   task_t       task_in;
   logic        done;
   logic        idle;
   task_t       task_out;
   logic        task_out_valid;
   logic        task_out_ready = 1'b1;
   rd_req_t     mem_rd_req;
   logic        mem_rd_valid;
   logic        mem_rd_ready;
   word_t       mem_rd_data;
   logic        mem_rd_resp_valid;
   wr_req_t     mem_wr_req;
   logic        mem_wr_valid;
   logic        mem_wr_ready;
   undo_entry_t undo_entry;
   logic        undo_valid;
   logic        undo_ready = 1'b1;

   logic        rd_gate = 1'b1;
   logic        wr_gate = 1'b1;
   logic [1:0]  rd_delay = 2'd0;
   logic        poke_en;
   addr_t       poke_addr;
   word_t       poke_data;

   logic [31:0] lcg = 32'd56246;
   int          cycles = 0;
   int          timeout_limit = 0;
   int          errors = 0;
   int          checks = 0;

   test_t       tests [$];
   addr_t       rd_log [$];
   undo_entry_t undo_log [$];
   time         undo_time [$];
   task_t       out_log [$];

   mflow_task_unit #(
      .HEADER_BASE (32'h0),
      .FLOW_IDX_W  (4)
   ) dut (.*);

   tb_mem_model mem (
      .clk           (clk),
      .rstn          (rstn),
      .rd_req        (mem_rd_req),
      .rd_valid      (mem_rd_valid),
      .rd_ready      (mem_rd_ready),
      .rd_data       (mem_rd_data),
      .rd_resp_valid (mem_rd_resp_valid),
      .wr_req        (mem_wr_req),
      .wr_valid      (mem_wr_valid),
      .wr_ready      (mem_wr_ready),
      .rd_gate       (rd_gate),
      .wr_gate       (wr_gate),
      .rd_delay      (rd_delay),
      .poke_en       (poke_en),
      .poke_addr     (poke_addr),
      .poke_data     (poke_data)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // each ready high about 3 cycles in 4
   always @(posedge clk) begin
      lcg = lcg_next(lcg);
      task_out_ready <= lcg[31] | lcg[30];
      undo_ready     <= lcg[29] | lcg[28];
      rd_gate        <= lcg[27] | lcg[26];
      wr_gate        <= lcg[25] | lcg[24];
      rd_delay       <= lcg[21:20];
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (rstn) begin
         if (mem_rd_valid && mem_rd_ready) begin
            rd_log.push_back(mem_rd_req.addr);
         end
         if (undo_valid && undo_ready) begin
            undo_log.push_back(undo_entry);
            undo_time.push_back($time);
         end
         if (task_out_valid && task_out_ready) begin
            out_log.push_back(task_out);
         end
      end
   end

   initial begin
      wait (timeout_limit > 0);
      wait (cycles >= timeout_limit);
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("test failed");
      $finish;
   end

   function automatic addr_t vertex_base(input vid_t obj);
      return VTX_BASE + obj * 32'd64;
   endfunction

   function automatic addr_t slot_addr(input vid_t obj, input word_t a0);
      return vertex_base(obj) + 32'd16 + (a0 % FLOW_SLOTS) * 32'd4;
   endfunction

   task automatic add_test(input string name, input ttype_t ttype, input vid_t obj,
                           input word_t arg0, input word_t arg1, input ts_t ts,
                           input word_t excess, input word_t height, input word_t flow,
                           input word_t new_excess, input word_t new_flow, input logic child,
                           input ttype_t c_type, input vid_t c_obj,
                           input word_t c_arg0, input word_t c_arg1);
      test_t t;
      t = '{name, ttype, obj, arg0, arg1, ts, excess, height, flow,
            new_excess, new_flow, child, '0};
      t.child_task = '{args: {c_arg1, c_arg0}, ttype: c_type, object: c_obj, ts: ts};
      tests.push_back(t);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp) else begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("expected %0d %s but saw %0d", exp, what, got);
         errors++;
      end
   endtask

   task automatic poke(input addr_t a, input word_t d);
      poke_en   <= 1'b1;
      poke_addr <= a;
      poke_data <= d;
      @(posedge clk);
      poke_en   <= 1'b0;
   endtask

   task automatic run_test(input int i);
      test_t       t;
      task_t       tk;
      addr_t       va;
      addr_t       fa;
      int          rd0;
      int          wr0;
      int          un0;
      int          out0;
      int          err0;
      int          k;
      addr_t       exp_rd [$];
      wr_req_t     exp_wr [$];
      undo_entry_t exp_un [$];
      task_t       exp_out [$];

      t    = tests[i];
      va   = vertex_base(t.obj);
      fa   = slot_addr(t.obj, t.arg0);
      err0 = errors;
      poke(va, t.excess);
      poke(va + 32'd8, t.height);
      poke(fa, t.flow);
      rd0  = rd_log.size();
      wr0  = mem.wr_log.size();
      un0  = undo_log.size();
      out0 = out_log.size();

      tk = '{args: {t.arg1, t.arg0}, ttype: t.ttype, object: t.obj, ts: t.ts};
      start   <= 1'b1;
      task_in <= tk;
      do @(negedge clk); while (!done);
      @(posedge clk);
      start   <= 1'b0;
      task_in <= '0;
      @(negedge clk);
      check_word("idle", word_t'(idle), 32'h1);
      @(posedge clk);

      if (i == 0) begin   // header is read first and only once
         exp_rd.push_back(32'h0);
         exp_rd.push_back(32'h4);
         exp_rd.push_back(32'h8);
      end
      if (t.ttype == GET_HEIGHT_TASK) begin
         exp_rd.push_back(va + 32'd8);
      end
      if (t.ttype == RECEIVE_TASK) begin
         exp_rd.push_back(va);
         exp_rd.push_back(fa);
         exp_un.push_back(undo_entry_t'{data: t.flow, addr: fa});
         exp_un.push_back(undo_entry_t'{data: t.excess, addr: va});
         exp_wr.push_back(wr_req_t'{data: t.new_flow, addr: fa});
         exp_wr.push_back(wr_req_t'{data: t.new_excess, addr: va});
      end
      if (t.child) begin
         exp_out.push_back(t.child_task);
      end

      check_count("memory reads", rd_log.size() - rd0, exp_rd.size());
      for (k = 0; k < exp_rd.size() && rd0 + k < rd_log.size(); k++) begin
         check_word("mem_rd_req.addr", rd_log[rd0 + k], exp_rd[k]);
      end
      check_count("undo entries", undo_log.size() - un0, exp_un.size());
      for (k = 0; k < exp_un.size() && un0 + k < undo_log.size(); k++) begin
         check_word("undo_entry.addr", undo_log[un0 + k].addr, exp_un[k].addr);
         check_word("undo_entry.data", undo_log[un0 + k].data, exp_un[k].data);
      end
      check_count("memory writes", mem.wr_log.size() - wr0, exp_wr.size());
      for (k = 0; k < exp_wr.size() && wr0 + k < mem.wr_log.size(); k++) begin
         check_word("mem_wr_req.addr", mem.wr_log[wr0 + k].addr, exp_wr[k].addr);
         check_word("mem_wr_req.data", mem.wr_log[wr0 + k].data, exp_wr[k].data);
         if (un0 + k < undo_log.size()) begin
            checks++;
            assert (undo_time[un0 + k] < mem.wr_time[wr0 + k]) else begin
               $display("undo entry %0d was not accepted before its write", k);
               errors++;
            end
         end
      end
      check_count("child tasks", out_log.size() - out0, exp_out.size());
      if (exp_out.size() == 1 && out_log.size() == out0 + 1) begin
         check_word("task_out.ts", out_log[out0].ts, exp_out[0].ts);
         check_word("task_out.object", out_log[out0].object, exp_out[0].object);
         check_word("task_out.ttype", word_t'(out_log[out0].ttype), word_t'(exp_out[0].ttype));
         check_word("task_out.args[31:0]", out_log[out0].args[31:0], exp_out[0].args[31:0]);
         check_word("task_out.args[63:32]", out_log[out0].args[63:32], exp_out[0].args[63:32]);
      end
      $display("test %0d %s: %s", i, t.name, (errors == err0) ? "ok" : "FAILED");
   endtask

   initial begin
      rstn      = 1'b0;
      start     = 1'b0;
      task_in   = '0;
      poke_en   = 1'b0;
      poke_addr = '0;
      poke_data = '0;

      // name, type, object, arg0, arg1, ts, excess, height, flow, excess and flow after,
      // child, child type, object, arg0, arg1
      add_test("get_height", GET_HEIGHT_TASK, 32'd5, 32'h9, 32'h77, 32'h10,
               32'h11, 32'h33, 32'h44, 32'h0, 32'h0, 1'b1, PUSH_TASK, 32'd9, 32'h33, 32'h77);
      add_test("receive_active", RECEIVE_TASK, 32'd6, 32'h13, 32'h5, 32'h20,
               32'h7, 32'h1, 32'h20, 32'hc, 32'h1b, 1'b0, PUSH_TASK, 32'd0, 32'h0, 32'h0);
      add_test("receive_wakes", RECEIVE_TASK, 32'd7, 32'h2, 32'h3, 32'h30,
               32'h0, 32'h2, 32'ha, 32'h3, 32'h7, 1'b1, DISCHARGE_TASK, 32'd7, 32'h0, 32'h30);
      add_test("receive_source", RECEIVE_TASK, SRC_NODE, 32'h1, 32'h4, 32'h40,
               32'h0, 32'h3, 32'h9, 32'h4, 32'h5, 1'b0, PUSH_TASK, 32'd0, 32'h0, 32'h0);
      add_test("receive_sink", RECEIVE_TASK, SNK_NODE, 32'hf, 32'h6, 32'h50,
               32'h0, 32'h4, 32'h6, 32'h6, 32'h0, 1'b0, PUSH_TASK, 32'd0, 32'h0, 32'h0);
      add_test("unknown_type", 3'd5, 32'd3, 32'h1, 32'h2, 32'h58,
               32'h0, 32'h5, 32'h1, 32'h0, 32'h0, 1'b0, PUSH_TASK, 32'd0, 32'h0, 32'h0);
      add_test("push_ignored", PUSH_TASK, 32'd4, 32'h3, 32'h8, 32'h5c,
               32'h2, 32'h6, 32'h3, 32'h0, 32'h0, 1'b0, PUSH_TASK, 32'd0, 32'h0, 32'h0);
      add_test("get_height_2", GET_HEIGHT_TASK, 32'd8, 32'h21, 32'hdead, 32'h60,
               32'h9, 32'h7, 32'h1, 32'h0, 32'h0, 1'b1, PUSH_TASK, 32'd33, 32'h7, 32'hdead);
      add_test("receive_wrap", RECEIVE_TASK, 32'd9, 32'h25, 32'h9, 32'h70,
               32'h100, 32'h8, 32'h2, 32'h109, 32'hfffffff9, 1'b0, PUSH_TASK, 32'd0, 32'h0,
               32'h0);
      add_test("receive_wakes_2", RECEIVE_TASK, 32'd10, 32'h40, 32'h1, 32'h80,
               32'h0, 32'h9, 32'h0, 32'h1, 32'hffffffff, 1'b1, DISCHARGE_TASK, 32'd10, 32'h0,
               32'h80);
      timeout_limit = tests.size() * PER_TEST_CYCLES + 50;

      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      poke(32'h0, VTX_BASE);   // graph header
      poke(32'h4, SRC_NODE);
      poke(32'h8, SNK_NODE);
      foreach (tests[i]) begin
         run_test(i);
      end

      $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
verilog/mflow_pkg.sv
verilog/header_loader.sv
verilog/mem_read_arbiter.sv
verilog/task_fsm.sv
verilog/mflow_task_unit.sv
verif/tb_mem_model.sv
verif/tb_task_unit.sv

// File: verilog/header_loader.sv
// graph header loader
`timescale 1ns/1ps

module header_loader import mflow_pkg::*; #(
   parameter addr_t HEADER_BASE = '0
) (
   input  logic    clk,
   input  logic    rstn,

   input  logic    start,

   output rd_req_t hdr_rd_req,
   output logic    hdr_rd_valid,
   input  logic    hdr_rd_ready,
   input  logic    hdr_resp_valid,
   input  word_t   rd_data,

   output logic    hdr_ready,
   output addr_t   base_vertex_data,
   output vid_t    source_node,
   output vid_t    sink_node
);

   logic [1:0] word_cnt;   // header word being fetched
   logic       loading;
   logic       waiting;    // read issued and response due

   assign hdr_rd_valid = loading && !waiting;
   assign hdr_rd_req.addr = HEADER_BASE + addr_t'({word_cnt, 2'b00});

   always_ff @(posedge clk) begin
      if (!rstn) begin
         word_cnt  <= '0;
         loading   <= 1'b0;
         waiting   <= 1'b0;
         hdr_ready <= 1'b0;
      end else begin
         if (start && !hdr_ready && !loading) begin
            loading <= 1'b1;   // first task after reset
         end
         if (hdr_rd_valid && hdr_rd_ready) begin
            waiting <= 1'b1;
         end
         if (hdr_resp_valid) begin
            waiting  <= 1'b0;
            word_cnt <= word_cnt + 2'd1;
            if (word_cnt == 2'd2) begin
               loading   <= 1'b0;
               hdr_ready <= 1'b1;   // sticky until reset
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_resp_valid) begin
         case (word_cnt)
            2'd0:    base_vertex_data <= rd_data;
            2'd1:    source_node      <= rd_data;
            default: sink_node        <= rd_data;
         endcase
      end
   end

   // once loaded, the header is never requested or returned again
   a_single_load: assert property (
      @(posedge clk) disable iff (!rstn)
      hdr_ready |-> !hdr_rd_valid && !hdr_resp_valid
   );

endmodule

// File: verilog/mem_read_arbiter.sv
// memory read port arbiter
`timescale 1ns/1ps

module mem_read_arbiter import mflow_pkg::*; (
   input  logic    clk,
   input  logic    rstn,

   input  rd_req_t hdr_rd_req,
   input  logic    hdr_rd_valid,
   output logic    hdr_rd_ready,
   output logic    hdr_resp_valid,

   input  rd_req_t fsm_rd_req,
   input  logic    fsm_rd_valid,
   output logic    fsm_rd_ready,
   output logic    fsm_resp_valid,

   output rd_req_t mem_rd_req,
   output logic    mem_rd_valid,
   input  logic    mem_rd_ready,
   input  logic    mem_rd_resp_valid
);

   logic pending;     // one read outstanding
   logic owner_hdr;   // outstanding read belongs to the header loader
   logic grant_hdr;

   assign grant_hdr = hdr_rd_valid;   // header loader wins

   assign mem_rd_valid = !pending && (hdr_rd_valid || fsm_rd_valid);
   assign mem_rd_req   = grant_hdr ? hdr_rd_req : fsm_rd_req;

   assign hdr_rd_ready = !pending && mem_rd_ready;
   assign fsm_rd_ready = !pending && mem_rd_ready && !grant_hdr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pending   <= 1'b0;
         owner_hdr <= 1'b0;
      end else if (mem_rd_valid && mem_rd_ready) begin
         pending   <= 1'b1;
         owner_hdr <= grant_hdr;
      end else if (mem_rd_resp_valid) begin
         pending   <= 1'b0;
      end
   end

   assign hdr_resp_valid = mem_rd_resp_valid && pending && owner_hdr;
   assign fsm_resp_valid = mem_rd_resp_valid && pending && !owner_hdr;

   // memory must not return data nobody asked for
   a_resp_pending: assert property (
      @(posedge clk) disable iff (!rstn)
      mem_rd_resp_valid |-> pending
   );

endmodule

// File: verilog/mflow_pkg.sv
// max-flow task unit types
package mflow_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [31:0] vid_t;
   typedef logic [31:0] ts_t;
   typedef logic [2:0]  ttype_t;

   // first member lands in the high bits, so ts ends up at bit 0
   typedef struct packed {
      logic [63:0] args;
      ttype_t      ttype;
      vid_t        object;
      ts_t         ts;
   } task_t;

   typedef struct packed {
      addr_t addr;
   } rd_req_t;

   typedef struct packed {
      word_t data;
      addr_t addr;
   } wr_req_t;

   typedef struct packed {
      word_t data;   // value before the store
      addr_t addr;
   } undo_entry_t;

   localparam ttype_t DISCHARGE_TASK  = 3'd0;
   localparam ttype_t GET_HEIGHT_TASK = 3'd1;
   localparam ttype_t PUSH_TASK       = 3'd2;
   localparam ttype_t RECEIVE_TASK    = 3'd3;

   // byte offsets inside a vertex record
   localparam int VID_EXCESS_OFFSET = 0;
   localparam int VID_HEIGHT_OFFSET = 8;

   // word index of flow slot 0
   localparam int FLOW_BASE_WORD = 4;

   localparam int VERTEX_SHIFT = 6;   // 64 byte vertex record

endpackage

// File: verilog/mflow_task_unit.sv
// max-flow task unit top
`timescale 1ns/1ps

module mflow_task_unit import mflow_pkg::*; #(
   parameter addr_t HEADER_BASE = '0,
   parameter int    FLOW_IDX_W  = 4
) (
   input  logic        clk,
   input  logic        rstn,

   input  logic        start,
   input  task_t       task_in,
   output logic        done,
   output logic        idle,

   output task_t       task_out,
   output logic        task_out_valid,
   input  logic        task_out_ready,

   output rd_req_t     mem_rd_req,
   output logic        mem_rd_valid,
   input  logic        mem_rd_ready,
   input  word_t       mem_rd_data,
   input  logic        mem_rd_resp_valid,

   output wr_req_t     mem_wr_req,
   output logic        mem_wr_valid,
   input  logic        mem_wr_ready,

   output undo_entry_t undo_entry,
   output logic        undo_valid,
   input  logic        undo_ready
);

   rd_req_t hdr_rd_req;
   logic    hdr_rd_valid;
   logic    hdr_rd_ready;
   logic    hdr_resp_valid;

   rd_req_t fsm_rd_req;
   logic    fsm_rd_valid;
   logic    fsm_rd_ready;
   logic    fsm_resp_valid;

   logic    hdr_ready;
   addr_t   base_vertex_data;
   vid_t    source_node;
   vid_t    sink_node;

   header_loader #(
      .HEADER_BASE (HEADER_BASE)
   ) u_header_loader (
      .clk              (clk),
      .rstn             (rstn),
      .start            (start),
      .hdr_rd_req       (hdr_rd_req),
      .hdr_rd_valid     (hdr_rd_valid),
      .hdr_rd_ready     (hdr_rd_ready),
      .hdr_resp_valid   (hdr_resp_valid),
      .rd_data          (mem_rd_data),
      .hdr_ready        (hdr_ready),
      .base_vertex_data (base_vertex_data),
      .source_node      (source_node),
      .sink_node        (sink_node)
   );

   mem_read_arbiter u_mem_read_arbiter (
      .clk               (clk),
      .rstn              (rstn),
      .hdr_rd_req        (hdr_rd_req),
      .hdr_rd_valid      (hdr_rd_valid),
      .hdr_rd_ready      (hdr_rd_ready),
      .hdr_resp_valid    (hdr_resp_valid),
      .fsm_rd_req        (fsm_rd_req),
      .fsm_rd_valid      (fsm_rd_valid),
      .fsm_rd_ready      (fsm_rd_ready),
      .fsm_resp_valid    (fsm_resp_valid),
      .mem_rd_req        (mem_rd_req),
      .mem_rd_valid      (mem_rd_valid),
      .mem_rd_ready      (mem_rd_ready),
      .mem_rd_resp_valid (mem_rd_resp_valid)
   );

   task_fsm #(
      .FLOW_IDX_W (FLOW_IDX_W)
   ) u_task_fsm (
      .clk              (clk),
      .rstn             (rstn),
      .start            (start),
      .task_in          (task_in),
      .done             (done),
      .idle             (idle),
      .hdr_ready        (hdr_ready),
      .base_vertex_data (base_vertex_data),
      .source_node      (source_node),
      .sink_node        (sink_node),
      .fsm_rd_req       (fsm_rd_req),
      .fsm_rd_valid     (fsm_rd_valid),
      .fsm_rd_ready     (fsm_rd_ready),
      .fsm_resp_valid   (fsm_resp_valid),
      .rd_data          (mem_rd_data),
      .mem_wr_req       (mem_wr_req),
      .mem_wr_valid     (mem_wr_valid),
      .mem_wr_ready     (mem_wr_ready),
      .undo_entry       (undo_entry),
      .undo_valid       (undo_valid),
      .undo_ready       (undo_ready),
      .task_out         (task_out),
      .task_out_valid   (task_out_valid),
      .task_out_ready   (task_out_ready)
   );

endmodule

// File: verilog/task_fsm.sv
// push-relabel task state machine
`timescale 1ns/1ps

module task_fsm import mflow_pkg::*; #(
   parameter int FLOW_IDX_W = 4
) (
   input  logic        clk,
   input  logic        rstn,

   input  logic        start,
   input  task_t       task_in,
   output logic        done,
   output logic        idle,

   input  logic        hdr_ready,
   input  addr_t       base_vertex_data,
   input  vid_t        source_node,
   input  vid_t        sink_node,

   output rd_req_t     fsm_rd_req,
   output logic        fsm_rd_valid,
   input  logic        fsm_rd_ready,
   input  logic        fsm_resp_valid,
   input  word_t       rd_data,

   output wr_req_t     mem_wr_req,
   output logic        mem_wr_valid,
   input  logic        mem_wr_ready,

   output undo_entry_t undo_entry,
   output logic        undo_valid,
   input  logic        undo_ready,

   output task_t       task_out,
   output logic        task_out_valid,
   input  logic        task_out_ready
);

   typedef enum logic [3:0] {
      IDLE,
      WAIT_HDR,
      GH_READ,
      GH_WAIT,
      GH_ENQ,
      RX_READ_EXCESS,
      RX_WAIT_EXCESS,
      RX_READ_FLOW,
      RX_WAIT_FLOW,
      RX_UNDO_FLOW,
      RX_WRITE_FLOW,
      RX_UNDO_EXCESS,
      RX_WRITE_EXCESS,
      RX_ENQ,
      FINISH
   } fsm_state_t;

   fsm_state_t state, state_next;

   task_t cur_task;
   word_t vid_excess;
   word_t vid_height;
   word_t edge_flow;

   word_t                 arg0;
   word_t                 arg1;   // flow amount for RECEIVE
   logic [FLOW_IDX_W-1:0] flow_idx;
   addr_t                 vertex_addr;
   addr_t                 excess_addr;
   addr_t                 height_addr;
   addr_t                 flow_addr;
   logic                  activates;

   assign arg0     = cur_task.args[31:0];
   assign arg1     = cur_task.args[63:32];
   assign flow_idx = arg0[FLOW_IDX_W-1:0];

   assign vertex_addr = base_vertex_data + (addr_t'(cur_task.object) << VERTEX_SHIFT);
   assign excess_addr = vertex_addr + addr_t'(VID_EXCESS_OFFSET);
   assign height_addr = vertex_addr + addr_t'(VID_HEIGHT_OFFSET);
   assign flow_addr   = vertex_addr + ((addr_t'(FLOW_BASE_WORD) + addr_t'(flow_idx)) << 2);

   // vertex turns active unless it is a terminal
   assign activates = (vid_excess == '0) && (cur_task.object != source_node)
                      && (cur_task.object != sink_node);

   assign done = (state == FINISH);
   assign idle = (state == IDLE);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && start) begin
         cur_task <= task_in;
      end
      if (fsm_resp_valid) begin
         case (state)
            GH_WAIT:        vid_height <= rd_data;
            RX_WAIT_EXCESS: vid_excess <= rd_data;
            RX_WAIT_FLOW:   edge_flow  <= rd_data;
            default: ;
         endcase
      end
   end

   always_comb begin
      state_next      = state;
      fsm_rd_valid    = 1'b0;
      fsm_rd_req.addr = '0;
      mem_wr_valid    = 1'b0;
      mem_wr_req      = '0;
      undo_valid      = 1'b0;
      undo_entry      = '0;
      task_out_valid  = 1'b0;
      task_out        = '0;

      case (state)
         IDLE: begin
            if (start) begin
               state_next = WAIT_HDR;
            end
         end
         WAIT_HDR: begin
            if (hdr_ready) begin
               case (cur_task.ttype)
                  GET_HEIGHT_TASK: state_next = GH_READ;
                  RECEIVE_TASK:    state_next = RX_READ_EXCESS;
                  default:         state_next = FINISH;   // nothing to do
               endcase
            end
         end
         GH_READ: begin
            fsm_rd_valid    = 1'b1;
            fsm_rd_req.addr = height_addr;
            if (fsm_rd_ready) begin
               state_next = GH_WAIT;
            end
         end
         GH_WAIT: begin
            if (fsm_resp_valid) begin
               state_next = GH_ENQ;
            end
         end
         GH_ENQ: begin
            task_out_valid  = 1'b1;
            task_out.ttype  = PUSH_TASK;
            task_out.object = arg0;
            task_out.args   = {arg1, vid_height};
            task_out.ts     = cur_task.ts;
            if (task_out_ready) begin
               state_next = FINISH;
            end
         end
         RX_READ_EXCESS: begin
            fsm_rd_valid    = 1'b1;
            fsm_rd_req.addr = excess_addr;
            if (fsm_rd_ready) begin
               state_next = RX_WAIT_EXCESS;
            end
         end
         RX_WAIT_EXCESS: begin
            if (fsm_resp_valid) begin
               state_next = RX_READ_FLOW;
            end
         end
         RX_READ_FLOW: begin
            fsm_rd_valid    = 1'b1;
            fsm_rd_req.addr = flow_addr;   // reverse edge slot
            if (fsm_rd_ready) begin
               state_next = RX_WAIT_FLOW;
            end
         end
         RX_WAIT_FLOW: begin
            if (fsm_resp_valid) begin
               state_next = RX_UNDO_FLOW;
            end
         end
         RX_UNDO_FLOW: begin
            undo_valid      = 1'b1;
            undo_entry.addr = flow_addr;
            undo_entry.data = edge_flow;
            if (undo_ready) begin
               state_next = RX_WRITE_FLOW;
            end
         end
         RX_WRITE_FLOW: begin
            mem_wr_valid    = 1'b1;
            mem_wr_req.addr = flow_addr;
            mem_wr_req.data = edge_flow - arg1;
            if (mem_wr_ready) begin
               state_next = RX_UNDO_EXCESS;
            end
         end
         RX_UNDO_EXCESS: begin
            undo_valid      = 1'b1;
            undo_entry.addr = excess_addr;
            undo_entry.data = vid_excess;
            if (undo_ready) begin
               state_next = RX_WRITE_EXCESS;
            end
         end
         RX_WRITE_EXCESS: begin
            mem_wr_valid    = 1'b1;
            mem_wr_req.addr = excess_addr;
            mem_wr_req.data = vid_excess + arg1;
            if (mem_wr_ready) begin
               state_next = activates ? RX_ENQ : FINISH;
            end
         end
         RX_ENQ: begin
            task_out_valid  = 1'b1;
            task_out.ttype  = DISCHARGE_TASK;
            task_out.object = cur_task.object;
            task_out.args   = {cur_task.ts, 32'd0};
            task_out.ts     = cur_task.ts;
            if (task_out_ready) begin
               state_next = FINISH;
            end
         end
         FINISH: begin
            state_next = IDLE;
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   // a stalled child task is held until the consumer takes it
   a_task_out_stable: assert property (
      @(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out)
   );

endmodule
